// ==== design/core_cfg_pkg.sv ====
// -------------------------------------------------------------------------
// Widths and sizes shared by every stage of the integer core
// Imported by the ISA package and by the RTL modules
// -------------------------------------------------------------------------

`default_nettype none

package core_cfg_pkg;

  // Datapath and register file
  localparam int XLEN       = 32;
  localparam int NR_REGS    = 8;
  localparam int REG_ADDR_W = $clog2(NR_REGS);
  localparam int IMM_W      = 12;

  // Performance counters
  localparam int CNT_W      = 32;

  typedef logic [XLEN-1:0]       data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [CNT_W-1:0]      cnt_t;

endpackage

`default_nettype wire

// ==== design/core_isa_pkg.sv ====
// -------------------------------------------------------------------------
// Instruction format, operation codes and the entries passed between
// the decode, issue and execute stages
// -------------------------------------------------------------------------

`default_nettype none

package core_isa_pkg;
  import core_cfg_pkg::*;

  // Codes 8 to 15 are illegal
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLT  = 4'd5,
    ADDI = 4'd6,
    SLL  = 4'd7
  } op_e;

  // Raw 32-bit instruction word as seen on the fetch port
  typedef struct packed {
    logic [3:0]              op;
    reg_addr_t               rd;
    reg_addr_t               rs1;
    reg_addr_t               rs2;
    logic [6:0]              reserved;
    logic signed [IMM_W-1:0] imm;
  } instr_t;

  // Decoded entry held in the ID stage
  typedef struct packed {
    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
    logic      use_imm;
    logic      writes_rd;
    logic      illegal;
  } decoded_t;

  // Operands ready for the ALU
  typedef struct packed {
    op_e       op;
    data_t     a;
    data_t     b;
    reg_addr_t rd;
    logic      writes_rd;
    logic      illegal;
  } issue_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    data_t     data;
    logic      writes_rd;
    logic      illegal;
  } commit_t;

endpackage

`default_nettype wire

// ==== design/id_stage.sv ====
// -------------------------------------------------------------------------
// Decode stage. Accepts words on the fetch handshake and keeps one
// decoded entry until the issue stage acknowledges it
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module id_stage (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   fetch_valid_i,
  input  core_isa_pkg::instr_t   fetch_instr_i,
  output logic                   fetch_ready_o,
  output core_isa_pkg::decoded_t decoded_o,
  output logic                   decoded_valid_o,
  input  logic                   issue_ack_i
);
  import core_cfg_pkg::*;
  import core_isa_pkg::*;

  decoded_t decoded_d;
  decoded_t entry_q;
  logic     valid_q;
  logic     fetch_xfer;

  // -----------------------------------------------------------------------
  // Decoder
  // -----------------------------------------------------------------------
  always_comb begin
    decoded_d     = '0;
    decoded_d.op  = op_e'(fetch_instr_i.op);
    decoded_d.rd  = fetch_instr_i.rd;
    decoded_d.rs1 = fetch_instr_i.rs1;
    decoded_d.rs2 = fetch_instr_i.rs2;
    // Sign-extend the immediate to a full word
    decoded_d.imm = {{(XLEN-IMM_W){fetch_instr_i.imm[IMM_W-1]}}, fetch_instr_i.imm};
    case (decoded_d.op)
      ADDI:                             decoded_d.use_imm = 1'b1;
      ADD, SUB, AND, OR, XOR, SLT, SLL: decoded_d.use_imm = 1'b0;
      default:                          decoded_d.illegal = 1'b1;
    endcase
    // Register 0 is never written
    decoded_d.writes_rd = !decoded_d.illegal && (decoded_d.rd != '0);
  end

  // -----------------------------------------------------------------------
  // Entry register
  // -----------------------------------------------------------------------
  // Ready when empty or when the held entry leaves this cycle
  assign fetch_ready_o = !valid_q || issue_ack_i;
  assign fetch_xfer    = fetch_valid_i && fetch_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (fetch_xfer) begin
      valid_q <= 1'b1;
    end else if (issue_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_xfer) begin
      entry_q <= decoded_d;
    end
  end

  assign decoded_o       = entry_q;
  assign decoded_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== design/issue_stage.sv ====
// -------------------------------------------------------------------------
// Issue stage with the register file and a one-entry scoreboard.
// Reads operands for the decoded entry and dispatches it to execute
// once it does not depend on the result being committed
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module issue_stage (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  core_isa_pkg::decoded_t decoded_i,
  input  logic                   decoded_valid_i,
  output logic                   issue_ack_o,
  output core_isa_pkg::issue_t   issue_o,
  output logic                   issue_valid_o,
  input  core_isa_pkg::commit_t  commit_i
);
  import core_cfg_pkg::*;
  import core_isa_pkg::*;

  data_t regs_q [NR_REGS];
  data_t rs1_data;
  data_t rs2_data;
  logic  commit_writes;
  logic  rs1_hit;
  logic  rs2_hit;
  logic  hazard;

  // -----------------------------------------------------------------------
  // Register file
  // -----------------------------------------------------------------------
  assign commit_writes = commit_i.valid && commit_i.writes_rd;

  // Written at the end of the commit valid cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (commit_writes) begin
      regs_q[commit_i.rd] <= commit_i.data;
    end
  end

  assign rs1_data = (decoded_i.rs1 == '0) ? '0 : regs_q[decoded_i.rs1];
  assign rs2_data = (decoded_i.rs2 == '0) ? '0 : regs_q[decoded_i.rs2];

  // -----------------------------------------------------------------------
  // Scoreboard
  // -----------------------------------------------------------------------
  // No bypass from the commit port so a match waits one cycle
  assign rs1_hit = decoded_i.rs1 == commit_i.rd;
  assign rs2_hit = !decoded_i.use_imm && (decoded_i.rs2 == commit_i.rd);

  // Illegal entries read nothing
  assign hazard = commit_writes && !decoded_i.illegal && (rs1_hit || rs2_hit);

  assign issue_ack_o   = decoded_valid_i && !hazard;
  assign issue_valid_o = issue_ack_o;

  // Operand selection
  always_comb begin
    issue_o.op        = decoded_i.op;
    issue_o.a         = rs1_data;
    issue_o.b         = decoded_i.use_imm ? decoded_i.imm : rs2_data;
    issue_o.rd        = decoded_i.rd;
    issue_o.writes_rd = decoded_i.writes_rd;
    issue_o.illegal   = decoded_i.illegal;
  end

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
// -------------------------------------------------------------------------
// Execute stage. Integer ALU followed by the commit register that
// drives the commit port for one cycle per retired instruction
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module ex_stage (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  core_isa_pkg::issue_t  issue_i,
  input  logic                  issue_valid_i,
  output core_isa_pkg::commit_t commit_o
);
  import core_cfg_pkg::*;
  import core_isa_pkg::*;

  data_t     result;
  logic      valid_q;
  reg_addr_t rd_q;
  data_t     data_q;
  logic      writes_rd_q;
  logic      illegal_q;

  // ALU
  always_comb begin
    case (issue_i.op)
      ADD, ADDI: result = issue_i.a + issue_i.b;
      SUB:       result = issue_i.a - issue_i.b;
      AND:       result = issue_i.a & issue_i.b;
      OR:        result = issue_i.a | issue_i.b;
      XOR:       result = issue_i.a ^ issue_i.b;
      SLT:       result = data_t'($signed(issue_i.a) < $signed(issue_i.b));
      SLL:       result = issue_i.a << issue_i.b[$clog2(XLEN)-1:0];
      // Illegal codes land here
      default:   result = '0;
    endcase
  end

  // -----------------------------------------------------------------------
  // Commit register
  // -----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      rd_q        <= issue_i.rd;
      data_q      <= result;
      writes_rd_q <= issue_i.writes_rd && !issue_i.illegal;
      illegal_q   <= issue_i.illegal;
    end
  end

  assign commit_o = '{
    valid:     valid_q,
    rd:        rd_q,
    data:      data_q,
    writes_rd: writes_rd_q,
    illegal:   illegal_q
  };

endmodule

`default_nettype wire

// ==== design/perf_counters.sv ====
// -------------------------------------------------------------------------
// Performance counters for retired and illegal instructions and for
// cycles where the decoded entry waits on the scoreboard
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module perf_counters (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  core_isa_pkg::commit_t commit_i,
  input  logic                  decoded_valid_i,
  input  logic                  issue_ack_i,
  output core_cfg_pkg::cnt_t    instret_o,
  output core_cfg_pkg::cnt_t    illegal_cnt_o,
  output core_cfg_pkg::cnt_t    stall_cnt_o
);
  import core_cfg_pkg::*;

  // All counters wrap
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      instret_o     <= '0;
      illegal_cnt_o <= '0;
      stall_cnt_o   <= '0;
    end else begin
      if (commit_i.valid && !commit_i.illegal) begin
        instret_o <= instret_o + cnt_t'(1);
      end
      if (commit_i.valid && commit_i.illegal) begin
        illegal_cnt_o <= illegal_cnt_o + cnt_t'(1);
      end
      // Entry waiting and not taken
      if (decoded_valid_i && !issue_ack_i) begin
        stall_cnt_o <= stall_cnt_o + cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
// -------------------------------------------------------------------------
// Top level of the in-order integer core. Words enter on the fetch
// handshake and retire in order on the commit port
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module core_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  fetch_valid_i,
  input  core_isa_pkg::instr_t  fetch_instr_i,
  output logic                  fetch_ready_o,
  output core_isa_pkg::commit_t commit_o,
  output core_cfg_pkg::cnt_t    instret_o,
  output core_cfg_pkg::cnt_t    illegal_cnt_o,
  output core_cfg_pkg::cnt_t    stall_cnt_o
);
  import core_isa_pkg::*;

  // ID <-> issue
  decoded_t decoded_id_issue;
  logic     decoded_valid_id_issue;
  logic     issue_ack_issue_id;

  // Issue <-> EX
  issue_t   issue_issue_ex;
  logic     issue_valid_issue_ex;

  id_stage u_id_stage (
    .clk_i           ( clk_i                  ),
    .reset_i         ( reset_i                ),
    .fetch_valid_i   ( fetch_valid_i          ),
    .fetch_instr_i   ( fetch_instr_i          ),
    .fetch_ready_o   ( fetch_ready_o          ),
    .decoded_o       ( decoded_id_issue       ),
    .decoded_valid_o ( decoded_valid_id_issue ),
    .issue_ack_i     ( issue_ack_issue_id     )
  );

  issue_stage u_issue_stage (
    .clk_i           ( clk_i                  ),
    .reset_i         ( reset_i                ),
    .decoded_i       ( decoded_id_issue       ),
    .decoded_valid_i ( decoded_valid_id_issue ),
    .issue_ack_o     ( issue_ack_issue_id     ),
    .issue_o         ( issue_issue_ex         ),
    .issue_valid_o   ( issue_valid_issue_ex   ),
    .commit_i        ( commit_o               )
  );

  ex_stage u_ex_stage (
    .clk_i         ( clk_i                ),
    .reset_i       ( reset_i              ),
    .issue_i       ( issue_issue_ex       ),
    .issue_valid_i ( issue_valid_issue_ex ),
    .commit_o      ( commit_o             )
  );

  perf_counters u_perf_counters (
    .clk_i           ( clk_i                  ),
    .reset_i         ( reset_i                ),
    .commit_i        ( commit_o               ),
    .decoded_valid_i ( decoded_valid_id_issue ),
    .issue_ack_i     ( issue_ack_issue_id     ),
    .instret_o       ( instret_o              ),
    .illegal_cnt_o   ( illegal_cnt_o          ),
    .stall_cnt_o     ( stall_cnt_o            )
  );

endmodule

`default_nettype wire

// ==== tb/tb_core_ref.svh ====
// -------------------------------------------------------------------------
// Reference model of the integer core and the random source for the
// testbench. Included inside the testbench module after its imports
// -------------------------------------------------------------------------

`ifndef TB_CORE_REF_SVH
`define TB_CORE_REF_SVH

  // Architectural state as the reference sees it
  data_t       model_regs [NR_REGS];
  logic [31:0] lfsr_q;

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value  = {value[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return value;
  endfunction

  // Applies one word to the model registers and returns its commit entry
  function automatic commit_t expected_commit(instr_t w);
    commit_t c;
    data_t   a;
    data_t   b;
    data_t   imm_x;
    data_t   res;
    logic    legal;
    a     = (w.rs1 == 0) ? data_t'(0) : model_regs[w.rs1];
    b     = (w.rs2 == 0) ? data_t'(0) : model_regs[w.rs2];
    imm_x = $signed(w.imm);
    legal = (w.op < 4'd8);
    case (w.op)
      4'd0:    res = a + b;
      4'd1:    res = a - b;
      4'd2:    res = a & b;
      4'd3:    res = a | b;
      4'd4:    res = a ^ b;
      4'd5:    res = ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
      4'd6:    res = a + imm_x;
      4'd7:    res = a << b[4:0];
      default: res = '0;
    endcase
    c.valid     = 1'b1;
    c.rd        = w.rd;
    c.data      = res;
    c.writes_rd = legal && (w.rd != 0);
    c.illegal   = !legal;
    if (c.writes_rd) begin
      model_regs[w.rd] = res;
    end
    return c;
  endfunction

`endif

// ==== tb/tb_core_top.sv ====
// -------------------------------------------------------------------------
// Testbench for the integer core. Sends random and directed words on the
// fetch port and checks every commit against the reference model
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_core_top;
  import core_cfg_pkg::*;
  import core_isa_pkg::*;

  localparam int SEED            = 78304;
  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 4;
  localparam int RANDOM_WORDS    = 300;
  localparam int BURST_WORDS     = 16;
  localparam int TOTAL_WORDS     = RANDOM_WORDS + 2 * BURST_WORDS;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * TOTAL_WORDS;

  logic    clk_i;
  logic    reset_i;
  logic    fetch_valid_i;
  instr_t  fetch_instr_i;
  logic    fetch_ready_o;
  commit_t commit_o;
  cnt_t    instret_o;
  cnt_t    illegal_cnt_o;
  cnt_t    stall_cnt_o;

  // Accepted words waiting for their commit
  instr_t sent_q [$];
  int     legal_sent;
  int     illegal_sent;

  `include "tb_core_ref.svh"

  core_top u_dut (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .fetch_valid_i ( fetch_valid_i ),
    .fetch_instr_i ( fetch_instr_i ),
    .fetch_ready_o ( fetch_ready_o ),
    .commit_o      ( commit_o      ),
    .instret_o     ( instret_o     ),
    .illegal_cnt_o ( illegal_cnt_o ),
    .stall_cnt_o   ( stall_cnt_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // -----------------------------------------------------------------------
  // Reporting and checks
  // -----------------------------------------------------------------------
  task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
    $display("Fail at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    $display("*** FAILED ***");
    $fatal(1, "Value mismatch on %s", name);
  endtask

  task automatic fail_text(string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1, "%s", what);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else fail_value(name, got, exp);
  endtask

  // -----------------------------------------------------------------------
  // Fetch driver
  // -----------------------------------------------------------------------
  // Called on a rising edge and returns on the edge of the transfer or after the gap
  task automatic send_word(instr_t w, int gap);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= w;
    @(posedge clk_i);
    while (!fetch_ready_o) @(posedge clk_i);
    sent_q.push_back(w);
    if (w.op < 4'd8) legal_sent++;
    else illegal_sent++;
    if (gap > 0) begin
      fetch_valid_i <= 1'b0;
      repeat (gap) @(posedge clk_i);
    end
  endtask

  task automatic wait_drain();
    while (sent_q.size() != 0) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  // Back-to-back burst where each source reads the rd of the word before
  // when dependent is set and never matches it otherwise
  task automatic send_burst(bit dependent);
    instr_t w;
    for (int k = 0; k < BURST_WORDS; k++) begin
      w     = '0;
      w.op  = dependent ? ((k % 2 == 0) ? 4'd6 : 4'd0) : 4'(k % 8);
      w.rd  = reg_addr_t'((k % 7) + 1);
      w.rs1 = dependent ? reg_addr_t'(((k + 6) % 7) + 1) : reg_addr_t'(((k + 5) % 7) + 1);
      w.rs2 = w.rs1;
      w.imm = take_bits(IMM_W);
      send_word(w, 0);
    end
    fetch_valid_i <= 1'b0;
  endtask

  // -----------------------------------------------------------------------
  // Commit comparison
  // -----------------------------------------------------------------------
  initial begin : compare_commits
    commit_t exp;
    instr_t  w;
    forever begin
      @(posedge clk_i);
      if (!reset_i && commit_o.valid === 1'b1) begin
        assert (sent_q.size() != 0)
          else fail_text("a commit arrived with no word outstanding");
        w   = sent_q.pop_front();
        exp = expected_commit(w);
        check_value("commit_o.rd", commit_o.rd, exp.rd);
        check_value("commit_o.data", commit_o.data, exp.data);
        check_value("commit_o.writes_rd", commit_o.writes_rd, exp.writes_rd);
        check_value("commit_o.illegal", commit_o.illegal, exp.illegal);
      end
    end
  end

  // Ends the run when words stop retiring
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    fail_text("timeout, commits stopped arriving before the test finished");
  end

  // -----------------------------------------------------------------------
  // Main sequence
  // -----------------------------------------------------------------------
  initial begin : main_sequence
    instr_t w;
    cnt_t   stall_before;
    lfsr_q        = SEED;
    reset_i       = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    legal_sent    = 0;
    illegal_sent  = 0;
    for (int i = 0; i < NR_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;

    // State right after reset
    @(negedge clk_i);
    check_value("fetch_ready_o", fetch_ready_o, 1);
    check_value("commit_o.valid", commit_o.valid, 0);
    check_value("instret_o", instret_o, 0);
    check_value("illegal_cnt_o", illegal_cnt_o, 0);
    check_value("stall_cnt_o", stall_cnt_o, 0);

    // Random stream with random idle gaps
    @(posedge clk_i);
    for (int i = 0; i < RANDOM_WORDS; i++) begin
      w = instr_t'(take_bits(32));
      send_word(w, int'(take_bits(2)));
    end
    fetch_valid_i <= 1'b0;
    wait_drain();
    check_value("illegal_cnt_o", illegal_cnt_o, illegal_sent);
    check_value("instret_o", instret_o, legal_sent);

    // Independent burst leaves the stall count alone
    stall_before = stall_cnt_o;
    @(posedge clk_i);
    send_burst(1'b0);
    wait_drain();
    check_value("stall_cnt_o", stall_cnt_o, stall_before);

    // Dependent burst stalls once per dependent word
    stall_before = stall_cnt_o;
    @(posedge clk_i);
    send_burst(1'b1);
    wait_drain();
    check_value("stall_cnt_o", stall_cnt_o, stall_before + cnt_t'(BURST_WORDS - 1));
    check_value("instret_o", instret_o, legal_sent);
    check_value("illegal_cnt_o", illegal_cnt_o, illegal_sent);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tb
design/core_cfg_pkg.sv
design/core_isa_pkg.sv
design/id_stage.sv
design/issue_stage.sv
design/ex_stage.sv
design/perf_counters.sv
design/core_top.sv
tb/tb_core_top.sv
